/* hw/bus_consts.svh */
`ifndef BUS_CONSTS_SVH
`define BUS_CONSTS_SVH

// main ram window, word organized
`define RAM_BASE        64'h0000_0000_0000_1000
`define RAM_WORDS       1024
`define RAM_BYTES       (`RAM_WORDS * 4)

// single-address peripheral registers
`define KEY_ADDR        64'h0000_0000_0000_8000
`define UART_ADDR       64'h0000_0000_0000_8008
`define SDC_ADDR_REG    64'h0000_0000_0000_8010
`define SDC_READ_REG    64'h0000_0000_0000_8018
`define SDC_READY_REG   64'h0000_0000_0000_8020
`define SDC_AVAIL_REG   64'h0000_0000_0000_8028

// sd sector buffer, one byte per address
`define SDC_BUF_BASE    64'h0000_0000_0000_9000
`define SDC_BUF_BYTES   512

`endif

/* hw/bus_pkg.sv */
package bus_pkg;

    // load/store width and sign, encoded as the cpu drives it
    // stores reuse the low two bits: sb 000, sh 001, sw 010, sd 011
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LD  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        LWU = 3'b110
    } access_t;

    // which block owns the current bus address
    typedef enum logic [3:0] {
        NONE     = 4'd0,
        RAM      = 4'd1,
        KEY      = 4'd2,
        UART     = 4'd3,
        SD_ADDR  = 4'd4,
        SD_READ  = 4'd5,
        SD_READY = 4'd6,
        SD_AVAIL = 4'd7,
        SD_BUF   = 4'd8
    } region_t;

endpackage

/* hw/bus_decoder.sv */
`include "bus_consts.svh"

module bus_decoder (
    input  logic [63:0]      address,
    output bus_pkg::region_t region
);
    import bus_pkg::*;

    logic ram_hit;
    logic buf_hit;

    // window compares, upper bound exclusive
    assign ram_hit = (address >= `RAM_BASE) && (address < `RAM_BASE + `RAM_BYTES);
    assign buf_hit = (address >= `SDC_BUF_BASE) &&
                     (address < `SDC_BUF_BASE + `SDC_BUF_BYTES);

    // exactly one region per address, unmatched falls to none
    always_comb begin
        region = NONE;
        if (ram_hit) begin
            region = RAM;
        end else if (buf_hit) begin
            region = SD_BUF;
        end else begin
            case (address)
                `KEY_ADDR:      region = KEY;
                `UART_ADDR:     region = UART;
                `SDC_ADDR_REG:  region = SD_ADDR;
                `SDC_READ_REG:  region = SD_READ;
                `SDC_READY_REG: region = SD_READY;
                `SDC_AVAIL_REG: region = SD_AVAIL;
                default:        region = NONE;
            endcase
        end
    end

    // memory map sanity: ram and sector buffer must not overlap
    a_windows_disjoint: assert final (!(ram_hit && buf_hit));

endmodule

/* hw/ram_port.sv */
`include "bus_consts.svh"

module ram_port (
    input  logic             clock_1hz,
    input  logic             KEY0,
    input  bus_pkg::region_t region,
    input  logic [63:0]      address,
    input  logic [63:0]      write_data,
    input  logic             write_enable,
    input  logic             read_enable,
    input  bus_pkg::access_t read_type,
    input  bus_pkg::access_t write_type,
    output logic             ram_valid,
    output logic [63:0]      ram_data
);
    import bus_pkg::*;

    localparam int IDX_W = $clog2(`RAM_WORDS);

    logic [31:0]      mem [0:`RAM_WORDS-1];
    logic [63:0]      ram_offset;
    logic [IDX_W-1:0] word_idx;
    logic [IDX_W-1:0] next_idx;
    logic [1:0]       byte_off;
    logic [2:0]       rd_code;
    logic [2:0]       wr_code;
    logic [31:0]      shifted;
    logic [31:0]      lo_word;
    logic [63:0]      load_value;
    logic [3:0]       lane_en;
    logic [31:0]      lane_data;
    logic             rd_start;
    logic             rd_active;
    logic             rd_beat;
    logic             rd_fetch_lo;
    logic             rd_finish;
    logic             wr_lo;
    logic             sd_hi_pend;

    function automatic logic aligned(input logic [1:0] size, input logic [2:0] off);
        case (size)
            2'b01:   aligned = (off[0] == 1'b0);
            2'b10:   aligned = (off[1:0] == 2'b00);
            2'b11:   aligned = (off == 3'b000);
            default: aligned = 1'b1;
        endcase
    endfunction

    // byte offset into the ram window
    assign ram_offset = address - `RAM_BASE;
    assign word_idx   = ram_offset[IDX_W+1:2];
    assign next_idx   = word_idx + 1'b1;
    assign byte_off   = ram_offset[1:0];
    assign rd_code    = read_type;
    assign wr_code    = write_type;

    // read sequencing: enable, optional low-word fetch for ld, then result
    assign rd_start    = read_enable && (region == RAM);
    assign rd_fetch_lo = rd_active && !rd_beat && (read_type == LD);
    assign rd_finish   = rd_active && !rd_fetch_lo;
    assign wr_lo       = write_enable && (region == RAM);

    // little endian, move addressed byte down to bit 0
    assign shifted = mem[word_idx] >> {byte_off, 3'b000};

    always_comb begin
        case (read_type)
            LB:      load_value = {{56{shifted[7]}}, shifted[7:0]};
            LBU:     load_value = {56'd0, shifted[7:0]};
            LH:      load_value = {{48{shifted[15]}}, shifted[15:0]};
            LHU:     load_value = {48'd0, shifted[15:0]};
            LW:      load_value = {{32{shifted[31]}}, shifted};
            LWU:     load_value = {32'd0, shifted};
            // upper word second, low word already captured
            LD:      load_value = {mem[next_idx], lo_word};
            default: load_value = 64'd0;
        endcase
    end

    // store lanes, data moved up to the addressed byte
    always_comb begin
        lane_data = write_data[31:0] << {byte_off, 3'b000};
        case (wr_code[1:0])
            2'b00:   lane_en = 4'b0001 << byte_off;
            2'b01:   lane_en = 4'b0011 << byte_off;
            default: lane_en = 4'b1111;
        endcase
    end

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            rd_active  <= 1'b0;
            rd_beat    <= 1'b0;
            ram_valid  <= 1'b0;
            sd_hi_pend <= 1'b0;
        end else begin
            ram_valid <= rd_finish;
            // sd upper word goes in the cycle after the enable
            sd_hi_pend <= wr_lo && (wr_code[1:0] == 2'b11);
            if (rd_start) begin
                rd_active <= 1'b1;
                rd_beat   <= 1'b0;
            end else if (rd_fetch_lo) begin
                rd_beat <= 1'b1;
            end else if (rd_finish) begin
                rd_active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock_1hz) begin
        if (wr_lo) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_en[b]) begin
                    mem[word_idx][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
        if (sd_hi_pend) begin
            mem[next_idx] <= write_data[63:32];
        end
        if (rd_fetch_lo) begin
            lo_word <= mem[word_idx];
        end
        if (rd_finish) begin
            ram_data <= load_value;
        end
    end

    // cpu never issues the unused 111 load code
    a_rd_type_valid: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        rd_start |-> (rd_code != 3'b111));

    // h, w, d accesses stay naturally aligned
    a_aligned: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        (rd_start |-> aligned(rd_code[1:0], ram_offset[2:0])) and
        (wr_lo |-> aligned(wr_code[1:0], ram_offset[2:0])));

endmodule

/* hw/periph_regs.sv */
`include "bus_consts.svh"

module periph_regs (
    input  logic             clock_1hz,
    input  logic             KEY0,
    input  bus_pkg::region_t region,
    input  logic [63:0]      address,
    input  logic [63:0]      write_data,
    input  logic             write_enable,
    input  logic             read_enable,
    input  logic [7:0]       key_ascii,
    input  logic             key_pressed,
    input  logic             interrupt_ack,
    output logic [3:0]       interrupt_vector,
    output logic [31:0]      sd_addr,
    output logic             sd_rd_start,
    input  logic [7:0]       sd_dout,
    input  logic             sd_byte_available,
    input  logic             sd_ready,
    output logic             uart_write_pulse,
    output logic [7:0]       uart_data,
    output logic             periph_valid,
    output logic [63:0]      periph_data
);
    import bus_pkg::*;

    localparam int BUF_IDX_W = $clog2(`SDC_BUF_BYTES);

    logic [7:0]           sd_buf [0:`SDC_BUF_BYTES-1];
    logic [7:0]           key_char;
    logic                 key_pressed_d;
    logic                 key_rise;
    logic                 sd_strobe_d;
    logic                 byte_take;
    logic                 last_byte;
    logic                 sd_read_hit;
    logic                 uart_hit;
    logic                 sd_avail;
    logic [BUF_IDX_W-1:0] byte_index;
    logic [63:0]          buf_offset;
    logic [BUF_IDX_W-1:0] buf_idx;
    logic                 rd_pend;
    logic [63:0]          rd_value;

    // edge detects on the slow side inputs
    assign key_rise  = key_pressed && !key_pressed_d;
    assign byte_take = sd_byte_available && !sd_strobe_d && sd_rd_start;
    assign last_byte = (byte_index == BUF_IDX_W'(`SDC_BUF_BYTES - 1));

    // new sector read only when the bridge is idle
    assign sd_read_hit = write_enable && (region == SD_READ) && !sd_rd_start;
    assign uart_hit    = write_enable && (region == UART);

    assign buf_offset = address - `SDC_BUF_BASE;
    assign buf_idx    = buf_offset[BUF_IDX_W-1:0];

    // read mux, everything not listed reads as zero
    always_comb begin
        case (region)
            KEY:      rd_value = {56'd0, key_char};
            SD_READY: rd_value = {63'd0, sd_ready};
            SD_AVAIL: rd_value = {63'd0, sd_avail};
            SD_BUF:   rd_value = {56'd0, sd_buf[buf_idx]};
            default:  rd_value = 64'd0;
        endcase
    end

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            key_pressed_d    <= 1'b0;
            key_char         <= 8'd0;
            interrupt_vector <= 4'd0;
            sd_strobe_d      <= 1'b0;
            sd_addr          <= 32'd0;
            sd_rd_start      <= 1'b0;
            sd_avail         <= 1'b0;
            byte_index       <= '0;
            uart_write_pulse <= 1'b0;
            rd_pend          <= 1'b0;
            periph_valid     <= 1'b0;
        end else begin
            key_pressed_d <= key_pressed;
            sd_strobe_d   <= sd_byte_available;
            if (key_rise) begin
                key_char <= key_ascii;
            end
            // ack clears, a fresh press in the same cycle wins
            if (interrupt_ack) begin
                interrupt_vector <= 4'd0;
            end
            if (key_rise && (key_ascii != 8'd0)) begin
                interrupt_vector <= 4'd1;
            end
            if (write_enable && (region == SD_ADDR)) begin
                sd_addr <= write_data[31:0];
            end
            if (sd_read_hit) begin
                sd_rd_start <= 1'b1;
                sd_avail    <= 1'b0;
                byte_index  <= '0;
            end else if (byte_take) begin
                byte_index <= byte_index + 1'b1;
                // full sector captured
                if (last_byte) begin
                    sd_avail    <= 1'b1;
                    sd_rd_start <= 1'b0;
                end
            end
            uart_write_pulse <= uart_hit;
            // answer one cycle after the enable, ram reads excluded
            rd_pend      <= read_enable && (region != RAM);
            periph_valid <= rd_pend;
        end
    end

    always_ff @(posedge clock_1hz) begin
        if (byte_take) begin
            sd_buf[byte_index] <= sd_dout;
        end
        if (uart_hit) begin
            uart_data <= write_data[7:0];
        end
        if (rd_pend) begin
            periph_data <= rd_value;
        end
    end

    // sd controller only streams bytes after a read start
    a_strobe_in_transfer: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        $rose(sd_byte_available) |-> sd_rd_start);

endmodule

/* hw/read_combiner.sv */
module read_combiner (
    input  logic        clock_1hz,
    input  logic        KEY0,
    input  logic        read_enable,
    input  logic        ram_valid,
    input  logic [63:0] ram_data,
    input  logic        periph_valid,
    input  logic [63:0] periph_data,
    output logic        bus_read_done,
    output logic [63:0] bus_read_data
);

    logic resp_take;

    // accept a response only while a read is outstanding
    assign resp_take = !bus_read_done && (ram_valid || periph_valid);

    // done is high when idle, low while a read is in flight
    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done <= 1'b1;
        end else if (resp_take) begin
            bus_read_done <= 1'b1;
        end else if (read_enable) begin
            bus_read_done <= 1'b0;
        end
    end

    // data lands in the same edge as done
    always_ff @(posedge clock_1hz) begin
        if (resp_take) begin
            bus_read_data <= ram_valid ? ram_data : periph_data;
        end
    end

    // decoder gives one owner per address
    a_one_responder: assert property (@(posedge clock_1hz) disable iff (!KEY0)
        !(ram_valid && periph_valid));

endmodule

/* hw/bus_subsystem.sv */
module bus_subsystem (
    input  logic             clock_1hz,
    input  logic             KEY0,
    // cpu bus
    input  logic [63:0]      bus_address,
    input  logic [63:0]      bus_write_data,
    input  logic             bus_write_enable,
    input  logic             bus_read_enable,
    input  bus_pkg::access_t bus_read_type,
    input  bus_pkg::access_t bus_write_type,
    output logic             bus_read_done,
    output logic [63:0]      bus_read_data,
    // keyboard and interrupt
    input  logic [7:0]       key_ascii,
    input  logic             key_pressed,
    output logic [3:0]       interrupt_vector,
    input  logic             interrupt_ack,
    // sd controller
    output logic [31:0]      sd_addr,
    output logic             sd_rd_start,
    input  logic [7:0]       sd_dout,
    input  logic             sd_byte_available,
    input  logic             sd_ready,
    // uart
    output logic             uart_write_pulse,
    output logic [7:0]       uart_data
);
    import bus_pkg::*;

    region_t     region;
    logic        ram_valid;
    logic [63:0] ram_data;
    logic        periph_valid;
    logic [63:0] periph_data;

    // address to region
    bus_decoder u_decoder (
        .address (bus_address),
        .region  (region)
    );

    // 4 KB ram
    ram_port u_ram (
        .clock_1hz    (clock_1hz),
        .KEY0         (KEY0),
        .region       (region),
        .address      (bus_address),
        .write_data   (bus_write_data),
        .write_enable (bus_write_enable),
        .read_enable  (bus_read_enable),
        .read_type    (bus_read_type),
        .write_type   (bus_write_type),
        .ram_valid    (ram_valid),
        .ram_data     (ram_data)
    );

    // keyboard, sd bridge, uart strobe
    periph_regs u_periph (
        .clock_1hz         (clock_1hz),
        .KEY0              (KEY0),
        .region            (region),
        .address           (bus_address),
        .write_data        (bus_write_data),
        .write_enable      (bus_write_enable),
        .read_enable       (bus_read_enable),
        .key_ascii         (key_ascii),
        .key_pressed       (key_pressed),
        .interrupt_ack     (interrupt_ack),
        .interrupt_vector  (interrupt_vector),
        .sd_addr           (sd_addr),
        .sd_rd_start       (sd_rd_start),
        .sd_dout           (sd_dout),
        .sd_byte_available (sd_byte_available),
        .sd_ready          (sd_ready),
        .uart_write_pulse  (uart_write_pulse),
        .uart_data         (uart_data),
        .periph_valid      (periph_valid),
        .periph_data       (periph_data)
    );

    // single read reply back to the cpu
    read_combiner u_combiner (
        .clock_1hz     (clock_1hz),
        .KEY0          (KEY0),
        .read_enable   (bus_read_enable),
        .ram_valid     (ram_valid),
        .ram_data      (ram_data),
        .periph_valid  (periph_valid),
        .periph_data   (periph_data),
        .bus_read_done (bus_read_done),
        .bus_read_data (bus_read_data)
    );

endmodule

/* tests/tb_bus_subsystem.sv */
`include "bus_consts.svh"

module tb_bus_subsystem;
    import bus_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int SIZED_ROUNDS   = 24;
    localparam int DOUBLE_ROUNDS  = 6;
    localparam int SD_SAMPLES     = 12;

    logic        clock_1hz;
    logic        KEY0;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic        bus_write_enable;
    logic        bus_read_enable;
    access_t     bus_read_type;
    access_t     bus_write_type;
    logic        bus_read_done;
    logic [63:0] bus_read_data;
    logic [7:0]  key_ascii;
    logic        key_pressed;
    logic [3:0]  interrupt_vector;
    logic        interrupt_ack;
    logic [31:0] sd_addr;
    logic        sd_rd_start;
    logic [7:0]  sd_dout;
    logic        sd_byte_available;
    logic        sd_ready;
    logic        uart_write_pulse;
    logic [7:0]  uart_data;

    // little endian byte image of the ram window
    logic [7:0] ref_mem [0:`RAM_BYTES-1];
    // bytes streamed into the sector buffer
    logic [7:0] sd_bytes [0:`SDC_BUF_BYTES-1];

    string      test_name;
    int         test_errors;
    int         tests_ok;
    int         tests_bad;
    int         uart_pulses;
    logic [7:0] uart_seen;

    bus_subsystem UUT (
        .clock_1hz         (clock_1hz),
        .KEY0              (KEY0),
        .bus_address       (bus_address),
        .bus_write_data    (bus_write_data),
        .bus_write_enable  (bus_write_enable),
        .bus_read_enable   (bus_read_enable),
        .bus_read_type     (bus_read_type),
        .bus_write_type    (bus_write_type),
        .bus_read_done     (bus_read_done),
        .bus_read_data     (bus_read_data),
        .key_ascii         (key_ascii),
        .key_pressed       (key_pressed),
        .interrupt_vector  (interrupt_vector),
        .interrupt_ack     (interrupt_ack),
        .sd_addr           (sd_addr),
        .sd_rd_start       (sd_rd_start),
        .sd_dout           (sd_dout),
        .sd_byte_available (sd_byte_available),
        .sd_ready          (sd_ready),
        .uart_write_pulse  (uart_write_pulse),
        .uart_data         (uart_data)
    );

    initial begin
        clock_1hz = 1'b0;
        forever #10 clock_1hz = ~clock_1hz;
    end

    // uart strobe monitor sampled at the falling edge
    always @(negedge clock_1hz) begin
        if (uart_write_pulse === 1'b1) begin
            uart_pulses++;
            uart_seen = uart_data;
        end
    end

    // every task starts and ends 2 units after a rising edge
    task automatic next_cycle();
        @(posedge clock_1hz);
        #2;
    endtask

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (actual !== expected) begin
            $display("ERR %s %s: expected %h, actual %h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic open_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            tests_ok++;
            $display("%s: ok", test_name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", test_name, test_errors);
        end
    endtask

    // size code 0..3 means 1, 2, 4, 8 bytes
    task automatic model_store(input logic [63:0] addr, input logic [63:0] data,
                               input logic [1:0] size);
        int base;
        base = int'(addr - `RAM_BASE);
        for (int i = 0; i < (1 << size); i++) begin
            ref_mem[base + i] = data[8*i +: 8];
        end
    endtask

    function automatic logic [63:0] model_load(input logic [63:0] addr, input logic [2:0] kind);
        logic [63:0] raw;
        int          base;
        int          nbytes;
        base   = int'(addr - `RAM_BASE);
        nbytes = 1 << kind[1:0];
        raw    = '0;
        for (int i = 0; i < nbytes; i++) begin
            raw[8*i +: 8] = ref_mem[base + i];
        end
        // bit 2 clear means signed so extend from the top loaded bit
        if (!kind[2] && nbytes < 8) begin
            for (int i = 8 * nbytes; i < 64; i++) begin
                raw[i] = raw[8*nbytes-1];
            end
        end
        return raw;
    endfunction

    task automatic bus_write(input logic [63:0] addr, input logic [63:0] data,
                             input access_t kind);
        bus_address      = addr;
        bus_write_data   = data;
        bus_write_type   = kind;
        bus_write_enable = 1'b1;
        next_cycle();
        bus_write_enable = 1'b0;
        // address and data held while sd writes the upper word
        next_cycle();
        next_cycle();
    endtask

    task automatic bus_read(input logic [63:0] addr, input access_t kind,
                            output logic [63:0] data);
        int waited;
        bus_address     = addr;
        bus_read_type   = kind;
        bus_read_enable = 1'b1;
        next_cycle();
        bus_read_enable = 1'b0;
        waited = 0;
        // done fell at the enable edge
        while (bus_read_done !== 1'b1 && waited < TIMEOUT_CYCLES) begin
            next_cycle();
            waited++;
        end
        if (bus_read_done !== 1'b1) begin
            $display("%s: read of %h timed out, bus_read_done never came back", test_name, addr);
            test_errors++;
            data = 'x;
        end else begin
            data = bus_read_data;
        end
    endtask

    task automatic pulse_key(input logic [7:0] ch);
        key_ascii   = ch;
        key_pressed = 1'b1;
        next_cycle();
        next_cycle();
        key_pressed = 1'b0;
        next_cycle();
    endtask

    // one byte per rising strobe
    task automatic send_sd_byte(input logic [7:0] value);
        sd_dout           = value;
        sd_byte_available = 1'b1;
        next_cycle();
        sd_byte_available = 1'b0;
        next_cycle();
    endtask

    task automatic reset_state();
        open_test("reset_state");
        check("bus_read_done", 64'd1, bus_read_done);
        check("interrupt_vector", 64'd0, interrupt_vector);
        check("sd_rd_start", 64'd0, sd_rd_start);
        check("uart_write_pulse", 64'd0, uart_write_pulse);
        close_test();
    endtask

    task automatic sized_store_readback();
        logic [63:0] word_addr;
        logic [63:0] addr;
        logic [63:0] read_addr;
        logic [63:0] data;
        logic [63:0] got;
        logic [1:0]  size;
        logic [2:0]  kcode;
        int          off;
        access_t     kinds [6];
        open_test("sized_store_readback");
        kinds = '{LB, LBU, LH, LHU, LW, LWU};
        for (int n = 0; n < SIZED_ROUNDS; n++) begin
            word_addr = `RAM_BASE + 64'(($urandom() % `RAM_WORDS) * 4);
            // background word so every read lane is known
            data = {$urandom(), $urandom()};
            bus_write(word_addr, data, LW);
            model_store(word_addr, data, 2'b10);
            // sb sh sw in turn aligned to their own size
            size = 2'(n % 3);
            off  = int'($urandom() % 4) & ~((1 << size) - 1);
            addr = word_addr + 64'(off);
            data = {$urandom(), $urandom()};
            bus_write(addr, data, access_t'({1'b0, size}));
            model_store(addr, data, size);
            foreach (kinds[k]) begin
                kcode     = kinds[k];
                read_addr = addr & ~64'((1 << kcode[1:0]) - 1);
                bus_read(read_addr, kinds[k], got);
                check($sformatf("%s at %h", kinds[k].name(), read_addr),
                      model_load(read_addr, kcode), got);
            end
        end
        close_test();
    endtask

    task automatic double_word_access();
        logic [63:0] addr;
        logic [63:0] data;
        logic [63:0] got;
        logic [31:0] hi_word;
        open_test("double_word_access");
        for (int n = 0; n < DOUBLE_ROUNDS; n++) begin
            addr = `RAM_BASE + 64'(($urandom() % (`RAM_WORDS / 2)) * 8);
            data = {$urandom(), $urandom()};
            // sd
            bus_write(addr, data, LD);
            model_store(addr, data, 2'b11);
            bus_read(addr, LD, got);
            check("ld after sd", data, got);
            bus_read(addr, LW, got);
            check("lw low word", model_load(addr, 3'b010), got);
            bus_read(addr + 4, LWU, got);
            check("lwu high word", model_load(addr + 4, 3'b110), got);
            bus_read(addr + 6, LH, got);
            check("lh top half", model_load(addr + 6, 3'b001), got);
            bus_read(addr + 7, LBU, got);
            check("lbu top byte", model_load(addr + 7, 3'b100), got);
            // new upper word must land in bits 63:32 of ld
            hi_word = $urandom();
            bus_write(addr + 4, {32'd0, hi_word}, LW);
            model_store(addr + 4, {32'd0, hi_word}, 2'b10);
            bus_read(addr, LD, got);
            check("ld word order", {hi_word, data[31:0]}, got);
        end
        close_test();
    endtask

    task automatic keyboard_interrupt();
        logic [7:0]  ch;
        logic [63:0] got;
        open_test("keyboard_interrupt");
        ch = 8'($urandom() % 255 + 1);
        pulse_key(ch);
        check("vector after press", 64'd1, interrupt_vector);
        bus_read(`KEY_ADDR, LBU, got);
        check("key char", ch, got);
        interrupt_ack = 1'b1;
        next_cycle();
        interrupt_ack = 1'b0;
        next_cycle();
        check("vector after ack", 64'd0, interrupt_vector);
        // zero char latches but raises nothing
        pulse_key(8'd0);
        check("vector after zero char", 64'd0, interrupt_vector);
        close_test();
    endtask

    task automatic sd_sector_read();
        logic [31:0] sector;
        logic [63:0] got;
        int          idx;
        open_test("sd_sector_read");
        sector = $urandom();
        bus_write(`SDC_ADDR_REG, {32'd0, sector}, LW);
        check("sd_addr", sector, sd_addr);
        sd_ready = 1'b1;
        next_cycle();
        bus_read(`SDC_READY_REG, LD, got);
        check("sd_ready high", 64'd1, got);
        sd_ready = 1'b0;
        next_cycle();
        bus_read(`SDC_READY_REG, LD, got);
        check("sd_ready low", 64'd0, got);
        bus_write(`SDC_READ_REG, 64'd1, LW);
        check("sd_rd_start raised", 64'd1, sd_rd_start);
        bus_read(`SDC_AVAIL_REG, LD, got);
        check("available during transfer", 64'd0, got);
        for (int i = 0; i < `SDC_BUF_BYTES; i++) begin
            sd_bytes[i] = 8'($urandom());
            send_sd_byte(sd_bytes[i]);
        end
        next_cycle();
        bus_read(`SDC_AVAIL_REG, LD, got);
        check("available after sector", 64'd1, got);
        check("sd_rd_start dropped", 64'd0, sd_rd_start);
        // first and last byte before random picks
        for (int n = 0; n < SD_SAMPLES; n++) begin
            if (n == 0) begin
                idx = 0;
            end else if (n == 1) begin
                idx = `SDC_BUF_BYTES - 1;
            end else begin
                idx = int'($urandom() % `SDC_BUF_BYTES);
            end
            bus_read(`SDC_BUF_BASE + 64'(idx), LBU, got);
            check($sformatf("buffer byte %0d", idx), sd_bytes[idx], got);
        end
        // a new read start clears the flag again
        bus_write(`SDC_READ_REG, 64'd1, LW);
        check("sd_rd_start raised again", 64'd1, sd_rd_start);
        bus_read(`SDC_AVAIL_REG, LD, got);
        check("available cleared by new read", 64'd0, got);
        close_test();
    endtask

    task automatic uart_and_unmapped();
        logic [63:0] data;
        logic [63:0] got;
        int          waited;
        open_test("uart_and_unmapped");
        data        = {$urandom(), $urandom()};
        uart_pulses = 0;
        bus_write(`UART_ADDR, data, LW);
        waited = 0;
        while (uart_pulses == 0 && waited < TIMEOUT_CYCLES) begin
            next_cycle();
            waited++;
        end
        if (uart_pulses == 0) begin
            $display("%s: no uart_write_pulse seen after the write", test_name);
            test_errors++;
        end
        repeat (4) next_cycle();
        check("uart pulse count", 64'd1, uart_pulses);
        check("uart byte", data[7:0], uart_seen);
        // gaps in the map still answer with zero
        bus_read(64'h0000_0000_0000_6000, LW, got);
        check("unmapped 0x6000", 64'd0, got);
        bus_read(64'h0000_0000_0000_8030, LD, got);
        check("unmapped 0x8030", 64'd0, got);
        close_test();
    endtask

    initial begin
        void'($urandom(88));
        KEY0              = 1'b0;
        bus_address       = '0;
        bus_write_data    = '0;
        bus_write_enable  = 1'b0;
        bus_read_enable   = 1'b0;
        bus_read_type     = LW;
        bus_write_type    = LW;
        key_ascii         = 8'd0;
        key_pressed       = 1'b0;
        interrupt_ack     = 1'b0;
        sd_dout           = 8'd0;
        sd_byte_available = 1'b0;
        sd_ready          = 1'b0;
        tests_ok          = 0;
        tests_bad         = 0;
        test_errors       = 0;
        uart_pulses       = 0;
        uart_seen         = 8'd0;
        repeat (5) @(posedge clock_1hz);
        #2;
        KEY0 = 1'b1;
        next_cycle();

        reset_state();
        sized_store_readback();
        double_word_access();
        keyboard_interrupt();
        sd_sector_read();
        uart_and_unmapped();

        $display("summary: %0d tests, %0d ok, %0d with errors",
                 tests_ok + tests_bad, tests_ok, tests_bad);
        if (tests_bad == 0 && test_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* bus_soc.f */
+incdir+hw
hw/bus_pkg.sv
hw/bus_decoder.sv
hw/ram_port.sv
hw/periph_regs.sv
hw/read_combiner.sv
hw/bus_subsystem.sv
tests/tb_bus_subsystem.sv
